//--- Makefile
# Verilator build and run of the serial-bus slave testbench

TOP       ?= tb_sbus_slave
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VERILATOR ?= verilator
FILELIST  ?= sources.f

VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides, so a crashed or hung run also counts as a failure
run: build
	./$(EXE) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- hw/sbus_defs.svh
// Bus and memory dimensions for the serial slave, included by every RTL source that needs them
`ifndef SBUS_DEFS_SVH
`define SBUS_DEFS_SVH

// bits per data word
`define SBUS_DATA_WIDTH 32

// RAM size in words and the address width that covers it
`define SBUS_ADDR_DEPTH 256
`define SBUS_ADDR_WIDTH 8

// slave identifier carried in each command frame
`define SBUS_ID_WIDTH 2

// three-bit pattern that opens every command frame
`define SBUS_START_CODE 3'b111

// start code, id, rw bit, burst bit, word address
`define SBUS_FRAME_LEN (3 + `SBUS_ID_WIDTH + 1 + 1 + `SBUS_ADDR_WIDTH)

`endif

//--- hw/sbus_frame_rx.sv
// Command frame receiver; shifts in control bits and strobes a decoded command that matches this slave
`include "sbus_defs.svh"

module sbus_frame_rx #(
    parameter sbus_pkg::slave_id_t SLAVE_ID = 1
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            control,
    input  logic            busy,
    output logic            cmd_strobe,
    output logic            cmd_write,
    output logic            cmd_burst,
    output sbus_pkg::addr_t cmd_addr
);
    import sbus_pkg::*;

    // field positions inside the frame, address at the bottom
    localparam int START_W   = $bits(`SBUS_START_CODE);
    localparam int BURST_BIT = `SBUS_ADDR_WIDTH;
    localparam int RW_BIT    = BURST_BIT + 1;
    localparam int ID_LSB    = RW_BIT + 1;
    localparam int START_LSB = ID_LSB + `SBUS_ID_WIDTH;

    bit_cnt_t                   cnt;
    logic [`SBUS_FRAME_LEN-1:0] frame;
    logic                       frame_done;
    logic                       take_bit;
    logic                       match;

    assign frame_done = (cnt == bit_cnt_t'(`SBUS_FRAME_LEN));

    // a new frame may only open while the controller is idle
    assign take_bit = !frame_done && ((cnt != '0) || (control && !busy));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt <= '0;
        end else if (frame_done) begin
            cnt <= '0;
        end else if (take_bit) begin
            cnt <= cnt + 1'b1;
        end
    end

    // MSB arrives first
    always_ff @(posedge clk) begin
        if (take_bit) begin
            frame <= {frame[`SBUS_FRAME_LEN-2:0], control};
        end
    end

    assign match = (frame[START_LSB +: START_W] == `SBUS_START_CODE) &&
                   (frame[ID_LSB +: `SBUS_ID_WIDTH] == SLAVE_ID);

    // frames for other slaves or with a bad start code just fall away
    assign cmd_strobe = frame_done && match;
    assign cmd_write  = frame[RW_BIT];
    assign cmd_burst  = frame[BURST_BIT];
    assign cmd_addr   = frame[`SBUS_ADDR_WIDTH-1:0];

endmodule

//--- hw/sbus_mem.sv
// Word RAM of the slave with one synchronous write port and a registered read port
`include "sbus_defs.svh"

module sbus_mem (
    input  logic                        clk,
    input  logic                        we,
    input  logic                        re,
    input  logic [`SBUS_ADDR_WIDTH-1:0] addr,
    input  logic [`SBUS_DATA_WIDTH-1:0] wdata,
    output logic [`SBUS_DATA_WIDTH-1:0] rdata
);

    logic [`SBUS_DATA_WIDTH-1:0] ram [`SBUS_ADDR_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            ram[addr] <= wdata;
        end
    end

    // read data valid the cycle after re
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= ram[addr];
        end
    end

endmodule

//--- hw/sbus_pkg.sv
// Shared types of the serial slave; modules import it to name words, addresses and FSM states
`include "sbus_defs.svh"

package sbus_pkg;

    // one data word as stored in RAM and moved on the bus
    typedef logic [`SBUS_DATA_WIDTH-1:0] data_t;

    // word address into the RAM
    typedef logic [`SBUS_ADDR_WIDTH-1:0] addr_t;

    // slave identifier as sent in the frame
    typedef logic [`SBUS_ID_WIDTH-1:0] slave_id_t;

    // wide enough to count all bits of a word, and of a frame
    typedef logic [$clog2(`SBUS_DATA_WIDTH):0] bit_cnt_t;

    // transfer controller states
    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ_FETCH,
        READ_SEND
    } xfer_state_t;

endpackage

//--- hw/sbus_rd_ser.sv
// Read serializer; loads a fetched word and shifts it out MSB first on rD, one bit per cycle
`include "sbus_defs.svh"

module sbus_rd_ser (
    input  logic            clk,
    input  logic            rstN,
    input  logic            load,
    input  sbus_pkg::data_t word,
    output logic            rD,
    output logic            shifting,
    output logic            word_done
);
    import sbus_pkg::*;

    // bits still to send, zero when idle
    bit_cnt_t remain;
    data_t    shreg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            remain <= '0;
        end else if (load) begin
            remain <= bit_cnt_t'(`SBUS_DATA_WIDTH);
        end else if (remain != '0) begin
            remain <= remain - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= word;
        end else if (remain != '0) begin
            shreg <= {shreg[`SBUS_DATA_WIDTH-2:0], 1'b0};
        end
    end

    assign shifting  = (remain != '0);
    assign word_done = (remain == bit_cnt_t'(1));

    // line stays low between words
    assign rD = shifting && shreg[`SBUS_DATA_WIDTH-1];

endmodule

//--- hw/sbus_slave.sv
// Top level of the serial-bus memory slave; connects receiver, deserializer, controller, RAM and serializer
`include "sbus_defs.svh"

module sbus_slave #(
    parameter sbus_pkg::slave_id_t SLAVE_ID = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready
);
    import sbus_pkg::*;

    // command path
    logic  cmd_strobe;
    logic  cmd_write;
    logic  cmd_burst;
    addr_t cmd_addr;
    logic  busy;

    // write path
    logic  wr_enable;
    logic  word_strobe;
    data_t word;
    logic  word_last;

    // RAM port
    logic  mem_we;
    logic  mem_re;
    addr_t mem_addr;
    data_t mem_wdata;
    data_t mem_rdata;

    // read path
    logic  load;
    logic  shifting;
    logic  word_done;

    sbus_frame_rx #(
        .SLAVE_ID (SLAVE_ID)
    ) i_frame_rx (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .busy       (busy),
        .cmd_strobe (cmd_strobe),
        .cmd_write  (cmd_write),
        .cmd_burst  (cmd_burst),
        .cmd_addr   (cmd_addr)
    );

    sbus_wr_deser i_wr_deser (
        .clk         (clk),
        .rstN        (rstN),
        .wD          (wD),
        .valid       (valid),
        .last        (last),
        .enable      (wr_enable),
        .word_strobe (word_strobe),
        .word        (word),
        .word_last   (word_last)
    );

    sbus_xfer_ctrl i_xfer_ctrl (
        .clk         (clk),
        .rstN        (rstN),
        .cmd_strobe  (cmd_strobe),
        .cmd_write   (cmd_write),
        .cmd_burst   (cmd_burst),
        .cmd_addr    (cmd_addr),
        .word_strobe (word_strobe),
        .word        (word),
        .word_last   (word_last),
        .last        (last),
        .shifting    (shifting),
        .word_done   (word_done),
        .busy        (busy),
        .wr_enable   (wr_enable),
        .mem_we      (mem_we),
        .mem_re      (mem_re),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .load        (load),
        .ready       (ready)
    );

    sbus_mem i_mem (
        .clk   (clk),
        .we    (mem_we),
        .re    (mem_re),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    sbus_rd_ser i_rd_ser (
        .clk       (clk),
        .rstN      (rstN),
        .load      (load),
        .word      (mem_rdata),
        .rD        (rD),
        .shifting  (shifting),
        .word_done (word_done)
    );

endmodule

//--- hw/sbus_wr_deser.sv
// Write data deserializer; collects valid-qualified wD bits and strobes each completed word
`include "sbus_defs.svh"

module sbus_wr_deser (
    input  logic            clk,
    input  logic            rstN,
    input  logic            wD,
    input  logic            valid,
    input  logic            last,
    input  logic            enable,
    output logic            word_strobe,
    output sbus_pkg::data_t word,
    output logic            word_last
);
    import sbus_pkg::*;

    bit_cnt_t cnt;
    logic     last_seen;
    logic     take_bit;

    assign take_bit = enable && valid;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt         <= '0;
            last_seen   <= 1'b0;
            word_strobe <= 1'b0;
            word_last   <= 1'b0;
        end else begin
            word_strobe <= 1'b0;
            if (!enable) begin
                // drop any partial word once the transfer is over
                cnt       <= '0;
                last_seen <= 1'b0;
            end else if (take_bit) begin
                if (cnt == bit_cnt_t'(`SBUS_DATA_WIDTH - 1)) begin
                    cnt         <= '0;
                    last_seen   <= 1'b0;
                    word_strobe <= 1'b1;
                    word_last   <= last_seen || last;
                end else begin
                    cnt       <= cnt + 1'b1;
                    last_seen <= last_seen || last;
                end
            end
        end
    end

    // word is stable for the strobe cycle, next bit lands one edge later
    always_ff @(posedge clk) begin
        if (take_bit) begin
            word <= {word[`SBUS_DATA_WIDTH-2:0], wD};
        end
    end

endmodule

//--- hw/sbus_xfer_ctrl.sv
// Transfer controller; sequences writes and reads between the serial side and the word RAM
`include "sbus_defs.svh"

module sbus_xfer_ctrl (
    input  logic            clk,
    input  logic            rstN,
    input  logic            cmd_strobe,
    input  logic            cmd_write,
    input  logic            cmd_burst,
    input  sbus_pkg::addr_t cmd_addr,
    input  logic            word_strobe,
    input  sbus_pkg::data_t word,
    input  logic            word_last,
    input  logic            last,
    input  logic            shifting,
    input  logic            word_done,
    output logic            busy,
    output logic            wr_enable,
    output logic            mem_we,
    output logic            mem_re,
    output sbus_pkg::addr_t mem_addr,
    output sbus_pkg::data_t mem_wdata,
    output logic            load,
    output logic            ready
);
    import sbus_pkg::*;

    xfer_state_t state;
    addr_t       addr;
    logic        burst;
    logic        last_seen;
    // second fetch cycle, read data is on mem_rdata
    logic        fetch_load;
    logic        write_end;
    logic        read_end;

    // a single transfer ends after one word, a burst on last
    assign write_end = !burst || word_last;
    assign read_end  = !burst || last_seen || last;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= IDLE;
            addr       <= '0;
            burst      <= 1'b0;
            last_seen  <= 1'b0;
            fetch_load <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_strobe) begin
                        addr       <= cmd_addr;
                        burst      <= cmd_burst;
                        last_seen  <= 1'b0;
                        fetch_load <= 1'b0;
                        state      <= cmd_write ? WRITE : READ_FETCH;
                    end
                end
                WRITE: begin
                    if (word_strobe) begin
                        addr <= addr + 1'b1;
                        if (write_end) begin
                            state <= IDLE;
                        end
                    end
                end
                READ_FETCH: begin
                    // request, then load
                    fetch_load <= !fetch_load;
                    if (fetch_load) begin
                        state <= READ_SEND;
                    end
                end
                READ_SEND: begin
                    if (last) begin
                        last_seen <= 1'b1;
                    end
                    if (word_done) begin
                        if (read_end) begin
                            state <= IDLE;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= READ_FETCH;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign busy      = (state != IDLE);
    assign wr_enable = (state == WRITE);

    // RAM requests
    assign mem_we    = wr_enable && word_strobe;
    assign mem_re    = (state == READ_FETCH) && !fetch_load;
    assign load      = (state == READ_FETCH) && fetch_load;
    assign mem_addr  = addr;
    assign mem_wdata = word;

    // ready idles high and drops from a read command through its fetch
    always_comb begin
        case (state)
            IDLE:       ready = !(cmd_strobe && !cmd_write);
            WRITE:      ready = 1'b1;
            READ_FETCH: ready = 1'b0;
            READ_SEND:  ready = shifting;
            default:    ready = 1'b1;
        endcase
    end

endmodule

//--- sim/tb_sbus_slave.sv
// Self-checking testbench of the serial-bus slave; sends frames, writes and reads words, checks RAM
`include "sbus_defs.svh"

module tb_sbus_slave;
    import sbus_pkg::*;

    localparam slave_id_t SLAVE_ID = 2'd1;
    localparam int PERIOD  = 40;
    localparam int DRV     = 5;
    localparam int MAX_GAP = 3;

    // cycle budget for the watchdog
    localparam int FRAME_CYC   = `SBUS_FRAME_LEN + 8;
    localparam int WR_WORD_CYC = `SBUS_DATA_WIDTH * (MAX_GAP + 1);
    localparam int RD_WORD_CYC = `SBUS_DATA_WIDTH + 8;
    localparam int N_FRAMES    = 10;
    localparam int N_WR_WORDS  = 8;
    localparam int N_RD_WORDS  = 8;
    localparam int RUN_CYC     = 16 + 10 + N_FRAMES * FRAME_CYC + N_WR_WORDS * WR_WORD_CYC +
                                 N_RD_WORDS * RD_WORD_CYC;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic ready;

    // expected RAM contents
    data_t model [`SBUS_ADDR_DEPTH];
    data_t wr_data [4];
    string test_name;
    int    errors;
    int    errors_at_start;
    int    tests_run;
    // high while a write frame and its data are on the bus
    logic  expect_ready;

    sbus_slave #(
        .SLAVE_ID (SLAVE_ID)
    ) i_dut (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rD      (rD),
        .ready   (ready)
    );

    always #(PERIOD / 2) clk = ~clk;

    // rD carries data only on ready cycles
    assert property (@(posedge clk) disable iff (!rstN) !ready |-> !rD)
        else begin
            errors++;
            $display("%s: rD high while ready is low", test_name);
        end

    // writes, accepted or ignored, never lower ready
    assert property (@(posedge clk) disable iff (!rstN) expect_ready |-> ready)
        else begin
            errors++;
            $display("%s: ready dropped during a write frame or its data", test_name);
        end

    task automatic next_cycle();
        @(posedge clk);
        #DRV;
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        int n;
        n = errors - errors_at_start;
        tests_run++;
        $display("%-10s %s, %0d error(s)", test_name, (n == 0) ? "ok" : "FAIL", n);
    endtask

    task automatic check_idle(input string where);
        assert (ready === 1'b1 && rD === 1'b0)
            else begin
                errors++;
                $display("Mismatch in %s %s: ready,rD expected 1,0, actual %b,%b",
                         test_name, where, ready, rD);
            end
    endtask

    // 15 bits MSB first, then control back low for the strobe cycle
    task automatic send_frame(input logic [2:0] start, input slave_id_t id, input logic write,
                              input logic burst, input addr_t addr);
        logic [`SBUS_FRAME_LEN-1:0] frame;
        frame = {start, id, write, burst, addr};
        for (int i = `SBUS_FRAME_LEN - 1; i >= 0; i--) begin
            next_cycle();
            control = frame[i];
        end
        next_cycle();
        control = 1'b0;
    endtask

    task automatic write_words(input logic [2:0] start, input slave_id_t id, input addr_t addr,
                               input int n, input logic burst);
        logic accept;
        int   gap;
        accept = (start == `SBUS_START_CODE) && (id == SLAVE_ID);
        for (int w = 0; w < n; w++) begin
            wr_data[w] = $urandom();
        end
        expect_ready = 1'b1;
        send_frame(start, id, 1'b1, burst, addr);
        for (int w = 0; w < n; w++) begin
            for (int b = `SBUS_DATA_WIDTH - 1; b >= 0; b--) begin
                gap = burst ? $urandom_range(0, MAX_GAP) : 0;
                repeat (gap) begin
                    next_cycle();
                    valid = 1'b0;
                    last  = 1'b0;
                end
                next_cycle();
                valid = 1'b1;
                wD    = wr_data[w][b];
                // one bit in the middle of the final word
                last  = burst && (w == n - 1) && (b == 12);
            end
        end
        next_cycle();
        valid = 1'b0;
        last  = 1'b0;
        wD    = 1'b0;
        // RAM write, then back to idle
        repeat (3) next_cycle();
        expect_ready = 1'b0;
        if (accept) begin
            for (int w = 0; w < n; w++) begin
                model[addr_t'(addr + w)] = wr_data[w];
            end
        end
    endtask

    task automatic read_words(input addr_t addr, input int n, input logic burst);
        data_t got;
        data_t exp;
        int    cnt;
        int    guard;
        send_frame(`SBUS_START_CODE, SLAVE_ID, 1'b0, burst, addr);
        @(negedge clk);
        assert (ready == 1'b0)
            else begin
                errors++;
                $display("%s: read command at %02h was not accepted", test_name, addr);
            end
        for (int w = 0; w < n; w++) begin
            got   = '0;
            cnt   = 0;
            guard = 0;
            while (cnt < `SBUS_DATA_WIDTH && guard < RD_WORD_CYC) begin
                @(negedge clk);
                guard++;
                if (ready) begin
                    got = {got[`SBUS_DATA_WIDTH-2:0], rD};
                    cnt++;
                end else begin
                    assert (cnt == 0)
                        else begin
                            errors++;
                            $display("%s: ready dropped inside read word %0d", test_name, w);
                        end
                end
                if (burst && w == n - 1 && cnt == 8) begin
                    next_cycle();
                    last = 1'b1;
                end
            end
            assert (cnt == `SBUS_DATA_WIDTH)
                else begin
                    errors++;
                    $display("%s: timeout waiting for bits of read word %0d", test_name, w);
                end
            exp = model[addr_t'(addr + w)];
            assert (got == exp)
                else begin
                    errors++;
                    $display("Mismatch in %s at %02h: expected %08h, actual %08h",
                             test_name, addr_t'(addr + w), exp, got);
                end
            // fetch gap after every word but the final one
            @(negedge clk);
            assert (ready == (w == n - 1))
                else begin
                    errors++;
                    $display("Mismatch in %s: ready after word %0d expected %0b, actual %0b",
                             test_name, w, (w == n - 1), ready);
                end
        end
        next_cycle();
        last = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_idle("after read");
        end
    endtask

    initial begin
        clk             = 1'b0;
        rstN            = 1'b0;
        control         = 1'b0;
        wD              = 1'b0;
        valid           = 1'b0;
        last            = 1'b0;
        expect_ready    = 1'b0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        test_name       = "setup";
        void'($urandom(18729));

        begin_test("reset");
        for (int i = 0; i < 16; i++) begin
            next_cycle();
            check_idle("during reset");
        end
        rstN = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_idle("after reset");
        end
        end_test();

        begin_test("single_rw");
        write_words(`SBUS_START_CODE, SLAVE_ID, 8'h3c, 1, 1'b0);
        read_words(8'h3c, 1, 1'b0);
        end_test();

        begin_test("burst_rw");
        write_words(`SBUS_START_CODE, SLAVE_ID, 8'h40, 4, 1'b1);
        read_words(8'h40, 4, 1'b1);
        end_test();

        // frame for slave 2, data must not land
        begin_test("wrong_id");
        write_words(`SBUS_START_CODE, 2'd2, 8'h3c, 1, 1'b0);
        read_words(8'h3c, 1, 1'b0);
        end_test();

        begin_test("bad_start");
        write_words(3'b101, SLAVE_ID, 8'h41, 1, 1'b0);
        write_words(`SBUS_START_CODE, SLAVE_ID, 8'h90, 1, 1'b0);
        read_words(8'h41, 1, 1'b0);
        read_words(8'h90, 1, 1'b0);
        end_test();

        $display("%0d tests, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(2 * RUN_CYC * PERIOD);
        $display("watchdog expired in %s after %0d cycles", test_name, 2 * RUN_CYC);
        $display("Test failed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+hw
hw/sbus_pkg.sv
hw/sbus_frame_rx.sv
hw/sbus_wr_deser.sv
hw/sbus_xfer_ctrl.sv
hw/sbus_mem.sv
hw/sbus_rd_ser.sv
hw/sbus_slave.sv
sim/tb_sbus_slave.sv
